// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = lb_board_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) testbench/lb_board_tests.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/lb_board_slave.sv
// --------------------
// Board local bus slave
// ID and status bank, statistics, write mirror and LED controls
// --------------------
`timescale 1ns/10ps

module lb_board_slave (
	input  logic              clk,
	input  logic              rst,
	input  lb_pkg::lb_req_t   req,
	output lb_pkg::lb_data_t  rdata,
	input  logic              xdomain_fault,
	input  lb_pkg::rx_event_t rx_event,
	input  logic              led_tick,
	output lb_pkg::led_duty_t led_duty_1,
	output lb_pkg::led_duty_t led_duty_2,
	output logic [1:0]        led_user_mode,
	output lb_pkg::misc_cfg_t cfg_out
);

	logic do_rd;
	logic local_write;
	logic [lb_pkg::MIRROR_AW-1:0] wr_offset;

	// Status counters
	logic [15:0] fault_count;
	logic [31:0] uptime;

	// Read pipeline
	logic                do_rd_r;
	lb_pkg::lb_addr_t    addr_r;
	lb_pkg::lb_data_t    bank0_r;
	lb_pkg::stat_count_t stat_r;
	lb_pkg::stat_count_t stat_count;
	lb_pkg::lb_data_t    mirror_word;

	// Counter clear, registered off the write
	logic stat_clear;

	assign do_rd = req.strobe && req.rd;
	assign local_write = req.strobe && !req.rd
		&& req.addr[23:16] == lb_pkg::REGION_WRITE;
	assign wr_offset = req.addr[lb_pkg::MIRROR_AW-1:0];

	// --------------------
	// Status counters
	// --------------------
	// Fault count wraps at 16 bits
	always_ff @(posedge clk) begin
		if (rst) begin
			fault_count <= '0;
		end else if (xdomain_fault) begin
			fault_count <= fault_count + 1'b1;
		end
	end

	// Uptime in PWM periods
	always_ff @(posedge clk) begin
		if (rst) begin
			uptime <= '0;
		end else if (led_tick) begin
			uptime <= uptime + 1'b1;
		end
	end

	stat_counter_bank u_stats (
		.clk        (clk),
		.rst        (rst),
		.event_in   (rx_event),
		.clear      (stat_clear),
		.read_cat   (req.addr[3:0]),
		.read_count (stat_count)
	);

	mirror_ram u_mirror (
		.clk     (clk),
		.wr_en   (local_write),
		.wr_addr (wr_offset),
		.rd_addr (req.addr[lb_pkg::MIRROR_AW-1:0]),
		.wr_data (req.wdata),
		.rd_data (mirror_word)
	);

	// --------------------
	// First read stage
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			do_rd_r <= 1'b0;
		end else begin
			do_rd_r <= do_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (do_rd) begin
			addr_r <= req.addr;
			// Stats latched here so a burst keeps its own address
			stat_r <= stat_count;
			case (req.addr[3:0])
				4'h0: bank0_r <= lb_pkg::HELLO_0;
				4'h1: bank0_r <= lb_pkg::HELLO_1;
				4'h2: bank0_r <= lb_pkg::HELLO_2;
				4'h3: bank0_r <= lb_pkg::HELLO_3;
				4'h4: bank0_r <= lb_pkg::lb_data_t'(fault_count);
				4'h5: bank0_r <= uptime;
				4'h6: bank0_r <= lb_pkg::lb_data_t'(cfg_out);
				4'h7: bank0_r <= lb_pkg::lb_data_t'(led_user_mode);
				4'h8: bank0_r <= lb_pkg::lb_data_t'(led_duty_1);
				4'h9: bank0_r <= lb_pkg::lb_data_t'(led_duty_2);
				default: bank0_r <= '0;
			endcase
		end
	end

	// --------------------
	// Second read stage
	// --------------------
	// Result holds until the next read lands
	always_ff @(posedge clk) begin
		if (rst) begin
			rdata <= '0;
		end else if (do_rd_r) begin
			if (addr_r[23:16] == lb_pkg::REGION_BANK0) begin
				rdata <= bank0_r;
			end else if (addr_r[23:12] == lb_pkg::REGION_STATS) begin
				rdata <= lb_pkg::lb_data_t'(stat_r);
			end else if (addr_r[23:16] == lb_pkg::REGION_WRITE) begin
				rdata <= mirror_word;
			end else begin
				rdata <= lb_pkg::UNMAPPED_WORD;
			end
		end
	end

	// --------------------
	// Direct writes
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			led_user_mode <= '0;
			led_duty_1 <= '0;
			led_duty_2 <= '0;
			cfg_out <= lb_pkg::MISC_CFG_DEFAULT;
			stat_clear <= 1'b0;
		end else begin
			stat_clear <= local_write && wr_offset == lb_pkg::WR_STAT_CLEAR;
			if (local_write) begin
				case (wr_offset)
					lb_pkg::WR_LED_MODE: led_user_mode <= req.wdata[1:0];
					lb_pkg::WR_DUTY_1:   led_duty_1 <= req.wdata[7:0];
					lb_pkg::WR_DUTY_2:   led_duty_2 <= req.wdata[7:0];
					lb_pkg::WR_MISC_CFG: cfg_out <= req.wdata[7:0];
					default: ;
				endcase
			end
		end
	end

	// Read or write must be decided on every strobe
	a_rd_known: assert property (
		@(posedge clk) disable iff (rst)
		req.strobe |-> !$isunknown(req.rd)
	) else $error("lb_board_slave: strobe with unknown rd");

	// PWM tick is a single-cycle pulse
	a_tick_pulse: assert property (
		@(posedge clk) disable iff (rst)
		led_tick |=> !led_tick
	) else $error("lb_board_slave: led_tick high on consecutive cycles");

endmodule

// File: hw/lb_board_top.sv
// --------------------
// Board local bus top
// Bus slave plus LED PWM driver
// --------------------
`timescale 1ns/10ps

module lb_board_top (
	input  logic              clk,
	input  logic              rst,
	input  lb_pkg::lb_req_t   req,
	output lb_pkg::lb_data_t  rdata,
	input  logic              xdomain_fault,
	input  lb_pkg::rx_event_t rx_event,
	output logic [1:0]        led_user_mode,
	output lb_pkg::misc_cfg_t cfg_out,
	output logic              led1,
	output logic              led2
);

	lb_pkg::led_duty_t led_duty_1;
	lb_pkg::led_duty_t led_duty_2;
	logic              led_tick;

	lb_board_slave u_slave (
		.clk           (clk),
		.rst           (rst),
		.req           (req),
		.rdata         (rdata),
		.xdomain_fault (xdomain_fault),
		.rx_event      (rx_event),
		.led_tick      (led_tick),
		.led_duty_1    (led_duty_1),
		.led_duty_2    (led_duty_2),
		.led_user_mode (led_user_mode),
		.cfg_out       (cfg_out)
	);

	// Tick also paces the uptime counter
	led_pwm u_pwm (
		.clk    (clk),
		.rst    (rst),
		.duty_1 (led_duty_1),
		.duty_2 (led_duty_2),
		.led1   (led1),
		.led2   (led2),
		.tick   (led_tick)
	);

endmodule

// File: hw/lb_pkg.sv
// --------------------
// Local bus package
// Bus, event and LED types, address map and ID words
// --------------------
package lb_pkg;

	// Bus word widths
	typedef logic [23:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;

	// One bus cycle as seen by the slave
	typedef struct packed {
		logic     strobe;
		logic     rd;
		lb_addr_t addr;
		lb_data_t wdata;
	} lb_req_t;

	// Packet statistics
	typedef logic [3:0] rx_cat_t;
	typedef logic [19:0] stat_count_t;

	typedef struct packed {
		logic    valid;
		rx_cat_t category;
	} rx_event_t;

	// Board controls
	typedef logic [7:0] led_duty_t;
	typedef logic [7:0] misc_cfg_t;

	localparam int LED_CW = 10;
	localparam int MIRROR_AW = 5;

	// Identification text, reads back as "Hello world!(::)"
	localparam lb_data_t HELLO_0 = "Hell";
	localparam lb_data_t HELLO_1 = "o wo";
	localparam lb_data_t HELLO_2 = "rld!";
	localparam lb_data_t HELLO_3 = "(::)";

	// --------------------
	// Address map
	// --------------------
	// Bank 0 on addr[23:16], stats on addr[23:12], writes on addr[23:16]
	localparam logic [7:0] REGION_BANK0 = 8'h00;
	localparam logic [11:0] REGION_STATS = 12'h041;
	localparam logic [7:0] REGION_WRITE = 8'h05;

	localparam lb_data_t UNMAPPED_WORD = 32'hdeadbeef;
	localparam misc_cfg_t MISC_CFG_DEFAULT = 8'h00;

	// Direct-write offsets inside REGION_WRITE
	localparam logic [MIRROR_AW-1:0] WR_LED_MODE = 5'd1;
	localparam logic [MIRROR_AW-1:0] WR_DUTY_1 = 5'd2;
	localparam logic [MIRROR_AW-1:0] WR_DUTY_2 = 5'd3;
	localparam logic [MIRROR_AW-1:0] WR_STAT_CLEAR = 5'd4;
	localparam logic [MIRROR_AW-1:0] WR_MISC_CFG = 5'd8;

endpackage

// File: hw/led_pwm.sv
// --------------------
// LED PWM
// Two duty-factor LED drivers and a period tick
// --------------------
`timescale 1ns/10ps

module led_pwm (
	input  logic              clk,
	input  logic              rst,
	input  lb_pkg::led_duty_t duty_1,
	input  lb_pkg::led_duty_t duty_2,
	output logic              led1,
	output logic              led2,
	output logic              tick
);

	logic [lb_pkg::LED_CW-1:0] pwm_cnt;
	logic [lb_pkg::LED_CW-1:0] thresh_1;
	logic [lb_pkg::LED_CW-1:0] thresh_2;

	// Duty scaled by four to span the full period
	assign thresh_1 = {duty_1, 2'b00};
	assign thresh_2 = {duty_2, 2'b00};

	// Free-running period counter
	always_ff @(posedge clk) begin
		if (rst) begin
			pwm_cnt <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
		end
	end

	// --------------------
	// Registered outputs
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
			tick <= 1'b0;
		end else begin
			led1 <= pwm_cnt < thresh_1;
			led2 <= pwm_cnt < thresh_2;
			// High for one cycle as the counter wraps
			tick <= &pwm_cnt;
		end
	end

endmodule

// File: hw/mirror_ram.sv
// --------------------
// Write mirror memory
// One write port, one registered read port
// --------------------
`timescale 1ns/10ps

module mirror_ram (
	input  logic                          clk,
	input  logic                          wr_en,
	input  logic [lb_pkg::MIRROR_AW-1:0]  wr_addr,
	input  logic [lb_pkg::MIRROR_AW-1:0]  rd_addr,
	input  lb_pkg::lb_data_t              wr_data,
	output lb_pkg::lb_data_t              rd_data
);

	lb_pkg::lb_data_t mem [1 << lb_pkg::MIRROR_AW];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Lines up with the slave's first read stage
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: hw/stat_counter_bank.sv
// --------------------
// Packet category statistics
// Sixteen wrapping event counters with a synchronous clear
// --------------------
`timescale 1ns/10ps

module stat_counter_bank (
	input  logic                  clk,
	input  logic                  rst,
	input  lb_pkg::rx_event_t     event_in,
	input  logic                  clear,
	input  lb_pkg::rx_cat_t       read_cat,
	output lb_pkg::stat_count_t   read_count
);

	lb_pkg::stat_count_t counts [16];

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			// Clear wins over a same-cycle event
			for (int i = 0; i < 16; i++) begin
				counts[i] <= '0;
			end
		end else if (event_in.valid) begin
			counts[event_in.category] <= counts[event_in.category] + 1'b1;
		end
	end

	// Read port straight off the counter registers
	assign read_count = counts[read_cat];

	// An event must name a real counter
	a_cat_known: assert property (
		@(posedge clk) disable iff (rst)
		event_in.valid |-> !$isunknown(event_in.category)
	) else $error("stat_counter_bank: unknown category on valid event");

endmodule

// File: testbench/lb_board_tests.svh
// --------------------
// Directed tests for the board local bus
// --------------------

task automatic test_ident_decode();
	lb_pkg::lb_data_t hello [4];
	lb_pkg::lb_addr_t burst_addr [6];
	lb_pkg::lb_data_t burst_exp [6];
	lb_pkg::lb_data_t got;
	hello[0] = "Hell";
	hello[1] = "o wo";
	hello[2] = "rld!";
	hello[3] = "(::)";
	for (int i = 0; i < 4; i++) begin
		bus_read(lb_pkg::lb_addr_t'(i), got);
		compare_data("rdata", got, hello[i]);
	end
	bus_read(24'h010000, got);
	compare_data("rdata", got, 32'hdeadbeef);
	bus_read(24'h040fff, got);
	compare_data("rdata", got, 32'hdeadbeef);
	bus_read(24'hff1234, got);
	compare_data("rdata", got, 32'hdeadbeef);
	// Back-to-back burst, one read per cycle
	burst_addr = '{24'h000003, 24'h000002, 24'h300000, 24'h000000, 24'h000001, 24'h060000};
	burst_exp = '{hello[3], hello[2], 32'hdeadbeef, hello[0], hello[1], 32'hdeadbeef};
	for (int i = 0; i < 8; i++) begin
		@(negedge clk);
		if (i >= 2) begin
			compare_data("rdata", rdata, burst_exp[i - 2]);
		end
		if (i < 6) begin
			req = '{strobe: 1'b1, rd: 1'b1, addr: burst_addr[i], wdata: '0};
		end else begin
			req = '0;
		end
	end
endtask

task automatic test_mirror();
	lb_pkg::lb_data_t written [32];
	lb_pkg::lb_data_t got;
	for (int i = 0; i < 32; i++) begin
		written[i] = lcg_next();
		bus_write(lb_pkg::lb_addr_t'(32'h050000 + i), written[i]);
	end
	for (int i = 0; i < 32; i++) begin
		bus_read(lb_pkg::lb_addr_t'(32'h050000 + i), got);
		compare_data("rdata", got, written[i]);
	end
endtask

task automatic test_control_regs();
	logic [1:0]        mode;
	lb_pkg::misc_cfg_t cfg;
	lb_pkg::lb_data_t  got;
	mode = 2'b10;
	cfg = lb_pkg::misc_cfg_t'(lcg_next() >> 24);
	bus_write(24'h050001, lb_pkg::lb_data_t'(mode));
	// Upper bytes must be ignored
	bus_write(24'h050008, {24'ha5a5a5, cfg});
	compare_data("led_user_mode", lb_pkg::lb_data_t'(led_user_mode), lb_pkg::lb_data_t'(mode));
	compare_cfg("cfg_out", cfg_out, cfg);
	bus_read(24'h000007, got);
	compare_data("rdata", got, lb_pkg::lb_data_t'(mode));
	bus_read(24'h000006, got);
	compare_data("rdata", got, lb_pkg::lb_data_t'(cfg));
endtask

task automatic test_statistics();
	lb_pkg::stat_count_t model [16];
	logic [31:0]         r;
	lb_pkg::lb_data_t    got;
	for (int i = 0; i < 16; i++) begin
		model[i] = '0;
	end
	bus_write(24'h050004, '0);
	for (int n = 0; n < STAT_EVENTS; n++) begin
		@(negedge clk);
		r = lcg_next();
		rx_event.valid = r[31];
		rx_event.category = r[27:24];
		if (r[31]) begin
			model[r[27:24]] = model[r[27:24]] + lb_pkg::stat_count_t'(1);
		end
	end
	@(negedge clk);
	rx_event = '0;
	for (int i = 0; i < 16; i++) begin
		bus_read(lb_pkg::lb_addr_t'(32'h041000 + i), got);
		compare_count("stat_count", got[19:0], model[i]);
		compare_data("rdata[31:20]", lb_pkg::lb_data_t'(got[31:20]), '0);
	end
	bus_write(24'h050004, lcg_next());
	for (int i = 0; i < 16; i++) begin
		bus_read(lb_pkg::lb_addr_t'(32'h041000 + i), got);
		compare_count("stat_count", got[19:0], '0);
	end
endtask

// Fault input has been low since reset
task automatic test_fault_count();
	lb_pkg::lb_data_t got;
	@(negedge clk);
	xdomain_fault = 1'b1;
	repeat (FAULT_CYCLES) @(negedge clk);
	xdomain_fault = 1'b0;
	bus_read(24'h000004, got);
	compare_data("fault_count", got, lb_pkg::lb_data_t'(FAULT_CYCLES));
endtask

// Count both LEDs over one full PWM period
task automatic measure_led_duty(input lb_pkg::led_duty_t duty_1,
	input lb_pkg::led_duty_t duty_2);
	int high_1;
	int high_2;
	high_1 = 0;
	high_2 = 0;
	bus_write(24'h050002, lb_pkg::lb_data_t'(duty_1));
	bus_write(24'h050003, lb_pkg::lb_data_t'(duty_2));
	repeat (4) @(negedge clk);
	repeat (1024) begin
		@(negedge clk);
		if (led1) begin
			high_1++;
		end
		if (led2) begin
			high_2++;
		end
	end
	compare_data("led1 high cycles", lb_pkg::lb_data_t'(high_1),
		lb_pkg::lb_data_t'(4 * int'(duty_1)));
	compare_data("led2 high cycles", lb_pkg::lb_data_t'(high_2),
		lb_pkg::lb_data_t'(4 * int'(duty_2)));
endtask

task automatic test_pwm_uptime();
	lb_pkg::lb_data_t up_first;
	lb_pkg::lb_data_t up_second;
	measure_led_duty(lb_pkg::led_duty_t'(lcg_next() >> 24) | 8'h01, 8'hff);
	measure_led_duty(8'h00, lb_pkg::led_duty_t'(lcg_next() >> 24) | 8'h01);
	measure_led_duty(8'hff, 8'h00);
	// Second read issued UPTIME_PERIODS full periods after the first
	bus_read(24'h000005, up_first);
	repeat (UPTIME_PERIODS * 1024 - 3) @(negedge clk);
	bus_read(24'h000005, up_second);
	compare_data("uptime delta", up_second - up_first, lb_pkg::lb_data_t'(UPTIME_PERIODS));
endtask

// File: testbench/lb_board_tb.sv
// --------------------
// Board local bus testbench
// Directed tests against lb_board_top
// --------------------
`timescale 1ns/10ps

module lb_board_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int STAT_EVENTS = 300;
	localparam int FAULT_CYCLES = 37;
	localparam int UPTIME_PERIODS = 3;
	// Rough cycle count of the whole sequence
	localparam int TEST_CYCLES = RESET_CYCLES + 40 + 64 * 3 + 30 + STAT_EVENTS + 32 * 3
		+ 60 + FAULT_CYCLES + 3 * (1024 + 12) + UPTIME_PERIODS * 1024 + 10;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

	logic              clk;
	logic              rst;
	lb_pkg::lb_req_t   req;
	lb_pkg::lb_data_t  rdata;
	logic              xdomain_fault;
	lb_pkg::rx_event_t rx_event;
	logic [1:0]        led_user_mode;
	lb_pkg::misc_cfg_t cfg_out;
	logic              led1;
	logic              led2;

	logic [31:0] lcg_state;

	lb_board_top uut (
		.clk           (clk),
		.rst           (rst),
		.req           (req),
		.rdata         (rdata),
		.xdomain_fault (xdomain_fault),
		.rx_event      (rx_event),
		.led_user_mode (led_user_mode),
		.cfg_out       (cfg_out),
		.led1          (led1),
		.led2          (led2)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic compare_data(input string name, input lb_pkg::lb_data_t got,
		input lb_pkg::lb_data_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic compare_cfg(input string name, input lb_pkg::misc_cfg_t got,
		input lb_pkg::misc_cfg_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic compare_count(input string name, input lb_pkg::stat_count_t got,
		input lb_pkg::stat_count_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// Write lands at the next edge, extra cycle covers the registered clear
	task automatic bus_write(input lb_pkg::lb_addr_t addr, input lb_pkg::lb_data_t data);
		@(negedge clk);
		req = '{strobe: 1'b1, rd: 1'b0, addr: addr, wdata: data};
		@(negedge clk);
		req = '0;
		@(negedge clk);
	endtask

	// Data valid two edges after the read is presented
	task automatic bus_read(input lb_pkg::lb_addr_t addr, output lb_pkg::lb_data_t data);
		@(negedge clk);
		req = '{strobe: 1'b1, rd: 1'b1, addr: addr, wdata: '0};
		@(negedge clk);
		req = '0;
		@(negedge clk);
		data = rdata;
	endtask

	`include "lb_board_tests.svh"

	// --------------------
	// Sequence
	// --------------------
	initial begin
		lcg_state = 32'd43;
		req = '0;
		xdomain_fault = 1'b0;
		rx_event = '0;
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		test_ident_decode();
		// Mirror runs early since its writes also hit the control offsets
		test_mirror();
		test_control_regs();
		test_statistics();
		test_fault_count();
		test_pwm_uptime();
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_now("Watchdog expired before the test sequence finished");
	end

endmodule

// File: verilog.f
+incdir+testbench
hw/lb_pkg.sv
hw/stat_counter_bank.sv
hw/mirror_ram.sv
hw/led_pwm.sv
hw/lb_board_slave.sv
hw/lb_board_top.sv
testbench/lb_board_tb.sv
